// File: project.f
+incdir+rtl
rtl/issue_pkg.sv
rtl/issue_decode.sv
rtl/hazard_unit.sv
rtl/pipe_tracker.sv
rtl/writeback_port.sv
rtl/issue_top.sv
verif/issue_tb.sv

// File: rtl/hazard_unit.sv
`default_nettype none

`include "issue_macros.svh"

module hazard_unit import issue_pkg::*; (
  input  wire                              pair_valid,
  input  wire                              is_branch,
  input  wire                              branch_taken,
  input  wire                              both_valid,
  input  wire                              even_from_slot1,
  input  wire                              even_rrr,
  input  wire pipe_t                       slot1_type,
  input  wire pipe_t                       slot2_type,
  input  wire reg_addr_t                   even_ra,
  input  wire reg_addr_t                   even_rb,
  input  wire reg_addr_t                   even_rc,
  input  wire reg_addr_t                   odd_ra,
  input  wire reg_addr_t                   odd_rb,
  input  wire reg_addr_t                   even_dst,
  input  wire reg_addr_t                   odd_dst,
  input  wire reg_addr_t [`PIPE_DEPTH-1:0] even_trk_dst,
  input  wire reg_addr_t [`PIPE_DEPTH-1:0] odd_trk_dst,
  input  wire logic      [`PIPE_DEPTH-1:0] even_trk_wr,
  input  wire logic      [`PIPE_DEPTH-1:0] odd_trk_wr,
  input  wire latency_t  [`PIPE_DEPTH-1:0] even_trk_lat,
  input  wire latency_t  [`PIPE_DEPTH-1:0] odd_trk_lat,
  output logic                             stall,
  output logic                             dependent_stall,
  output logic                             flush,
  output logic                             issue_even,
  output logic                             issue_odd
);

  reg_addr_t [4:0] srcs;
  logic      [4:0] src_used;
  logic            hazard;
  logic            pair_conflict;
  logic            go;

  // An entry at position p still blocks readers while its latency exceeds p+1
  function automatic logic pipe_hit(
    input reg_addr_t                   src,
    input reg_addr_t [`PIPE_DEPTH-1:0] dst,
    input logic      [`PIPE_DEPTH-1:0] wr,
    input latency_t  [`PIPE_DEPTH-1:0] lat
  );
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < `PIPE_DEPTH; p++) begin
      if (wr[p] && dst[p] == src && lat[p] > latency_t'(p + 1)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  assign srcs     = {odd_rb, odd_ra, even_rc, even_rb, even_ra};
  assign src_used = {1'b1, 1'b1, even_rrr, 1'b1, 1'b1}; // rc only matters for RRR forms

  always_comb begin
    hazard = 1'b0;
    for (int s = 0; s < 5; s++) begin
      if (src_used[s]) begin
        hazard = hazard
               | pipe_hit(srcs[s], even_trk_dst, even_trk_wr, even_trk_lat)
               | pipe_hit(srcs[s], odd_trk_dst, odd_trk_wr, odd_trk_lat);
      end
    end
  end

  assign pair_conflict = (slot1_type == slot2_type) || (even_dst == odd_dst);

  // Branches are predicted not-taken, so a taken one discards the pair
  assign flush = pair_valid && is_branch && branch_taken;

  assign stall = pair_valid && !flush && hazard;

  assign dependent_stall = pair_valid && both_valid && !flush && !stall && pair_conflict;

  assign go = pair_valid && !flush && !stall;

  // On a dependent stall only the pipe holding slot 1 takes its instruction
  assign issue_even = go && (!dependent_stall || even_from_slot1);
  assign issue_odd  = go && (!dependent_stall || !even_from_slot1);

endmodule

`default_nettype wire

// File: rtl/issue_decode.sv
`default_nettype none

`include "issue_macros.svh"

module issue_decode import issue_pkg::*; (
  input  wire instr_id_t slot1_id,
  input  wire instr_id_t slot2_id,
  input  wire reg_addr_t slot1_dst,
  input  wire reg_addr_t slot1_ra,
  input  wire reg_addr_t slot1_rb,
  input  wire reg_addr_t slot1_rc,
  input  wire reg_addr_t slot2_dst,
  input  wire reg_addr_t slot2_ra,
  input  wire reg_addr_t slot2_rb,
  input  wire reg_addr_t slot2_rc,
  output reg_addr_t      even_ra,
  output reg_addr_t      even_rb,
  output reg_addr_t      even_rc,
  output reg_addr_t      odd_ra,
  output reg_addr_t      odd_rb,
  output reg_addr_t      even_dst,
  output reg_addr_t      odd_dst,
  output logic           even_rrr,
  output logic           even_wr,
  output logic           odd_wr,
  output logic           both_valid,
  output latency_t       even_lat,
  output latency_t       odd_lat,
  output pipe_t          slot1_type,
  output pipe_t          slot2_type,
  output logic           even_from_slot1
);

  latency_t slot1_lat;
  latency_t slot2_lat;
  logic     slot1_wr;
  logic     slot2_wr;
  logic     slot1_rrr;
  logic     slot2_rrr;

  function automatic void lookup(
    input  instr_id_t id,
    output pipe_t     typ,
    output latency_t  lat,
    output logic      wr,
    output logic      rrr
  );
    typ = even_pipe; // Unknown ids behave as an even nop
    lat = `LAT_NOP;
    wr  = 1'b0;
    rrr = 1'b0;
    case (id)
      `INSTR_ID_LNOP:   begin typ = odd_pipe; lat = `LAT_LNOP; end
      `INSTR_ID_STOP:   begin typ = odd_pipe; lat = `LAT_STOP; end
      `INSTR_ID_A:      begin lat = `LAT_A; wr = 1'b1; end
      `INSTR_ID_FA:     begin lat = `LAT_FA; wr = 1'b1; end
      `INSTR_ID_FMA:    begin lat = `LAT_FMA; wr = 1'b1; rrr = 1'b1; end
      `INSTR_ID_MPYA:   begin lat = `LAT_MPYA; wr = 1'b1; rrr = 1'b1; end
      `INSTR_ID_SELB:   begin lat = `LAT_SELB; wr = 1'b1; rrr = 1'b1; end
      `INSTR_ID_SHLQBY: begin typ = odd_pipe; lat = `LAT_SHLQBY; wr = 1'b1; end
      `INSTR_ID_LQD:    begin typ = odd_pipe; lat = `LAT_LQD; wr = 1'b1; end
      `INSTR_ID_BR:     begin typ = odd_pipe; lat = `LAT_BR; end
      default:          ;
    endcase
  endfunction

  function automatic logic is_idle(input instr_id_t id);
    return id inside {`INSTR_ID_NOP, `INSTR_ID_LNOP, `INSTR_ID_STOP};
  endfunction

  always_comb begin
    lookup(slot1_id, slot1_type, slot1_lat, slot1_wr, slot1_rrr);
    lookup(slot2_id, slot2_type, slot2_lat, slot2_wr, slot2_rrr);
  end

  // Slot 1 always keeps its own pipe, slot 2 gets whichever role is left
  assign even_from_slot1 = (slot1_type == even_pipe);

  assign both_valid = !is_idle(slot1_id) && !is_idle(slot2_id);

  assign even_ra  = even_from_slot1 ? slot1_ra  : slot2_ra;
  assign even_rb  = even_from_slot1 ? slot1_rb  : slot2_rb;
  assign even_rc  = even_from_slot1 ? slot1_rc  : slot2_rc;
  assign even_dst = even_from_slot1 ? slot1_dst : slot2_dst;
  assign even_lat = even_from_slot1 ? slot1_lat : slot2_lat;
  assign even_wr  = even_from_slot1 ? slot1_wr  : slot2_wr;
  assign even_rrr = even_from_slot1 ? slot1_rrr : slot2_rrr;

  assign odd_ra  = even_from_slot1 ? slot2_ra  : slot1_ra;
  assign odd_rb  = even_from_slot1 ? slot2_rb  : slot1_rb;
  assign odd_dst = even_from_slot1 ? slot2_dst : slot1_dst;
  assign odd_lat = even_from_slot1 ? slot2_lat : slot1_lat;
  assign odd_wr  = even_from_slot1 ? slot2_wr  : slot1_wr;

endmodule

`default_nettype wire

// File: rtl/issue_macros.svh
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

`define PIPE_DEPTH 7 // In-flight positions per pipe

// Instruction ids as seen by the issue stage
`define INSTR_ID_NOP    7'd1  // Even filler
`define INSTR_ID_LNOP   7'd2  // Odd filler
`define INSTR_ID_STOP   7'd3
`define INSTR_ID_A      7'd10
`define INSTR_ID_FA     7'd20
`define INSTR_ID_FMA    7'd21 // Three source operands
`define INSTR_ID_MPYA   7'd30 // Three source operands
`define INSTR_ID_SELB   7'd40 // Three source operands
`define INSTR_ID_SHLQBY 7'd50
`define INSTR_ID_LQD    7'd60
`define INSTR_ID_BR     7'd70

// Result latency in cycles, zero for ids that never write
`define LAT_NOP    4'd0
`define LAT_LNOP   4'd0
`define LAT_STOP   4'd0
`define LAT_A      4'd2
`define LAT_FA     4'd6
`define LAT_FMA    4'd6
`define LAT_MPYA   4'd7
`define LAT_SELB   4'd2
`define LAT_SHLQBY 4'd4
`define LAT_LQD    4'd6
`define LAT_BR     4'd0

`endif

// File: rtl/issue_pkg.sv
`default_nettype none

package issue_pkg;

  // One of the 128 vector registers
  typedef logic [6:0] reg_addr_t;

  typedef logic [6:0] instr_id_t;

  typedef logic [3:0] latency_t; // Cycles until the result can be read

  // Execution pipe an instruction belongs to
  typedef enum logic {
    even_pipe = 1'b0, // Arithmetic
    odd_pipe  = 1'b1  // Load, shift and branch
  } pipe_t;

endpackage

`default_nettype wire

// File: rtl/issue_top.sv
`default_nettype none

`include "issue_macros.svh"

module issue_top import issue_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire            pair_valid,
  input  wire instr_id_t slot1_id,
  input  wire reg_addr_t slot1_dst,
  input  wire reg_addr_t slot1_ra,
  input  wire reg_addr_t slot1_rb,
  input  wire reg_addr_t slot1_rc,
  input  wire instr_id_t slot2_id,
  input  wire reg_addr_t slot2_dst,
  input  wire reg_addr_t slot2_ra,
  input  wire reg_addr_t slot2_rb,
  input  wire reg_addr_t slot2_rc,
  input  wire            is_branch,
  input  wire            branch_taken,
  output logic           stall,
  output logic           dependent_stall,
  output logic           flush,
  output logic           issue_even,
  output logic           issue_odd,
  output logic           wb_even_valid,
  output logic           wb_odd_valid,
  output reg_addr_t      wb_even_reg,
  output reg_addr_t      wb_odd_reg,
  output logic [15:0]    retired_count
);

  reg_addr_t even_ra;
  reg_addr_t even_rb;
  reg_addr_t even_rc;
  reg_addr_t odd_ra;
  reg_addr_t odd_rb;
  reg_addr_t even_dst;
  reg_addr_t odd_dst;
  logic      even_rrr;
  logic      even_wr;
  logic      odd_wr;
  logic      both_valid;
  latency_t  even_lat;
  latency_t  odd_lat;
  pipe_t     slot1_type;
  pipe_t     slot2_type;
  logic      even_from_slot1;

  reg_addr_t [`PIPE_DEPTH-1:0] even_trk_dst;
  reg_addr_t [`PIPE_DEPTH-1:0] odd_trk_dst;
  latency_t  [`PIPE_DEPTH-1:0] even_trk_lat;
  latency_t  [`PIPE_DEPTH-1:0] odd_trk_lat;
  logic      [`PIPE_DEPTH-1:0] even_trk_wr;
  logic      [`PIPE_DEPTH-1:0] odd_trk_wr;
  logic                        even_out_valid;
  logic                        odd_out_valid;
  reg_addr_t                   even_out_dst;
  reg_addr_t                   odd_out_dst;

  issue_decode u_decode (
    .slot1_id        (slot1_id),
    .slot2_id        (slot2_id),
    .slot1_dst       (slot1_dst),
    .slot1_ra        (slot1_ra),
    .slot1_rb        (slot1_rb),
    .slot1_rc        (slot1_rc),
    .slot2_dst       (slot2_dst),
    .slot2_ra        (slot2_ra),
    .slot2_rb        (slot2_rb),
    .slot2_rc        (slot2_rc),
    .even_ra         (even_ra),
    .even_rb         (even_rb),
    .even_rc         (even_rc),
    .odd_ra          (odd_ra),
    .odd_rb          (odd_rb),
    .even_dst        (even_dst),
    .odd_dst         (odd_dst),
    .even_rrr        (even_rrr),
    .even_wr         (even_wr),
    .odd_wr          (odd_wr),
    .both_valid      (both_valid),
    .even_lat        (even_lat),
    .odd_lat         (odd_lat),
    .slot1_type      (slot1_type),
    .slot2_type      (slot2_type),
    .even_from_slot1 (even_from_slot1)
  );

  hazard_unit u_hazard (
    .pair_valid      (pair_valid),
    .is_branch       (is_branch),
    .branch_taken    (branch_taken),
    .both_valid      (both_valid),
    .even_from_slot1 (even_from_slot1),
    .even_rrr        (even_rrr),
    .slot1_type      (slot1_type),
    .slot2_type      (slot2_type),
    .even_ra         (even_ra),
    .even_rb         (even_rb),
    .even_rc         (even_rc),
    .odd_ra          (odd_ra),
    .odd_rb          (odd_rb),
    .even_dst        (even_dst),
    .odd_dst         (odd_dst),
    .even_trk_dst    (even_trk_dst),
    .odd_trk_dst     (odd_trk_dst),
    .even_trk_wr     (even_trk_wr),
    .odd_trk_wr      (odd_trk_wr),
    .even_trk_lat    (even_trk_lat),
    .odd_trk_lat     (odd_trk_lat),
    .stall           (stall),
    .dependent_stall (dependent_stall),
    .flush           (flush),
    .issue_even      (issue_even),
    .issue_odd       (issue_odd)
  );

  // Arithmetic pipe
  pipe_tracker u_even_trk (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue_even),
    .dst_in    (even_dst),
    .wr_in     (even_wr),
    .lat_in    (even_lat),
    .trk_dst   (even_trk_dst),
    .trk_lat   (even_trk_lat),
    .trk_wr    (even_trk_wr),
    .out_valid (even_out_valid),
    .out_dst   (even_out_dst)
  );

  // Load, shift and branch pipe
  pipe_tracker u_odd_trk (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue_odd),
    .dst_in    (odd_dst),
    .wr_in     (odd_wr),
    .lat_in    (odd_lat),
    .trk_dst   (odd_trk_dst),
    .trk_lat   (odd_trk_lat),
    .trk_wr    (odd_trk_wr),
    .out_valid (odd_out_valid),
    .out_dst   (odd_out_dst)
  );

  writeback_port u_wb (
    .clk            (clk),
    .rst            (rst),
    .even_out_valid (even_out_valid),
    .odd_out_valid  (odd_out_valid),
    .even_out_dst   (even_out_dst),
    .odd_out_dst    (odd_out_dst),
    .wb_even_valid  (wb_even_valid),
    .wb_odd_valid   (wb_odd_valid),
    .wb_even_reg    (wb_even_reg),
    .wb_odd_reg     (wb_odd_reg),
    .retired_count  (retired_count)
  );

endmodule

`default_nettype wire

// File: rtl/pipe_tracker.sv
`default_nettype none

`include "issue_macros.svh"

module pipe_tracker import issue_pkg::*; #(
  parameter int depth = `PIPE_DEPTH
) (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        issue,
  input  wire reg_addr_t             dst_in,
  input  wire                        wr_in,
  input  wire latency_t              lat_in,
  output reg_addr_t [depth-1:0]      trk_dst,
  output latency_t  [depth-1:0]      trk_lat,
  output logic      [depth-1:0]      trk_wr,
  output logic                       out_valid,
  output reg_addr_t                  out_dst
);

  logic     wr_new;
  latency_t lat_new;

  // Idle cycles push a bubble that never writes
  assign wr_new  = issue && wr_in;
  assign lat_new = issue ? lat_in : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      trk_wr <= '0;
    end else begin
      trk_wr <= {trk_wr[depth-2:0], wr_new};
    end
  end

  // Entries advance one position every cycle, position 0 is the newest
  always_ff @(posedge clk) begin
    trk_dst <= {trk_dst[depth-2:0], dst_in};
    trk_lat <= {trk_lat[depth-2:0], lat_new};
  end

  assign out_valid = trk_wr[depth-1]; // Writing entry about to leave the pipe
  assign out_dst   = trk_dst[depth-1];

endmodule

`default_nettype wire

// File: rtl/writeback_port.sv
`default_nettype none

module writeback_port import issue_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire            even_out_valid,
  input  wire            odd_out_valid,
  input  wire reg_addr_t even_out_dst,
  input  wire reg_addr_t odd_out_dst,
  output logic           wb_even_valid,
  output logic           wb_odd_valid,
  output reg_addr_t      wb_even_reg,
  output reg_addr_t      wb_odd_reg,
  output logic [15:0]    retired_count
);

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_even_valid <= 1'b0;
      wb_odd_valid  <= 1'b0;
      retired_count <= '0;
    end else begin
      wb_even_valid <= even_out_valid;
      wb_odd_valid  <= odd_out_valid;
      // Both pipes can retire in the same cycle
      retired_count <= retired_count + 16'(even_out_valid) + 16'(odd_out_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (even_out_valid) begin
      wb_even_reg <= even_out_dst;
    end
    if (odd_out_valid) begin
      wb_odd_reg <= odd_out_dst;
    end
  end

endmodule

`default_nettype wire

// File: verif/issue_tb.sv
`default_nettype none

`include "issue_macros.svh"

module issue_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int timeout_cycles = 2000; // 300 random pairs plus directed tests, with margin

  logic clk = 1'b0;
  logic rst;
  logic pair_valid, is_branch, branch_taken;
  logic [6:0] slot1_id, slot1_dst, slot1_ra, slot1_rb, slot1_rc;
  logic [6:0] slot2_id, slot2_dst, slot2_ra, slot2_rb, slot2_rc;
  logic stall, dependent_stall, flush, issue_even, issue_odd;
  logic wb_even_valid, wb_odd_valid;
  logic [6:0] wb_even_reg, wb_odd_reg;
  logic [15:0] retired_count;

  int errors = 0;
  int cycles = 0;
  logic [6:0] st_id [2], st_dst [2], st_ra [2], st_rb [2], st_rc [2];
  logic [6:0] instr_ids [11];

  // Reference tables, index 0 is the even pipe and 1 the odd pipe
  logic [6:0] m_dst [2][7];
  logic       m_wr [2][7];
  logic [3:0] m_lat [2][7];
  logic [7:0] i1, i2;
  logic [6:0] e_ra, e_rb, e_rc, o_ra, o_rb, e_dst, o_dst;
  logic       e_rrr, e_wr, o_wr, hz, go;
  logic [3:0] e_lat, o_lat;
  logic       x_flush, x_stall, x_dep, x_iss_even, x_iss_odd;
  logic       x_wb_ev, x_wb_od;
  logic [6:0] x_wb_ev_reg, x_wb_od_reg;
  logic [15:0] x_retired;

  issue_top u_dut (.*);

  always #4 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  // Returns {odd pipe, writes, three sources, filler, latency}
  function automatic logic [7:0] instr_info(input logic [6:0] id);
    case (id)
      `INSTR_ID_LNOP, `INSTR_ID_STOP: return {4'b1001, 4'd0};
      `INSTR_ID_A:      return {4'b0100, 4'd2};
      `INSTR_ID_FA:     return {4'b0100, 4'd6};
      `INSTR_ID_FMA:    return {4'b0110, 4'd6};
      `INSTR_ID_MPYA:   return {4'b0110, 4'd7};
      `INSTR_ID_SELB:   return {4'b0110, 4'd2};
      `INSTR_ID_SHLQBY: return {4'b1100, 4'd4};
      `INSTR_ID_LQD:    return {4'b1100, 4'd6};
      `INSTR_ID_BR:     return {4'b1000, 4'd0};
      default:          return {4'b0001, 4'd0}; // nop
    endcase
  endfunction

  always_comb begin
    i1 = instr_info(slot1_id);
    i2 = instr_info(slot2_id);
    e_ra  = i1[7] ? slot2_ra : slot1_ra; // Slot 1 keeps its own pipe
    e_rb  = i1[7] ? slot2_rb : slot1_rb;
    e_rc  = i1[7] ? slot2_rc : slot1_rc;
    e_rrr = i1[7] ? i2[5] : i1[5];
    e_dst = i1[7] ? slot2_dst : slot1_dst;
    e_wr  = i1[7] ? i2[6] : i1[6];
    e_lat = i1[7] ? i2[3:0] : i1[3:0];
    o_ra  = i1[7] ? slot1_ra : slot2_ra;
    o_rb  = i1[7] ? slot1_rb : slot2_rb;
    o_dst = i1[7] ? slot1_dst : slot2_dst;
    o_wr  = i1[7] ? i1[6] : i2[6];
    o_lat = i1[7] ? i1[3:0] : i2[3:0];
    hz = 1'b0;
    for (int q = 0; q < 2; q++) begin
      for (int p = 0; p < 7; p++) begin
        if (m_wr[q][p] && m_lat[q][p] > p + 1) begin
          if (m_dst[q][p] == e_ra || m_dst[q][p] == e_rb || (e_rrr && m_dst[q][p] == e_rc) ||
              m_dst[q][p] == o_ra || m_dst[q][p] == o_rb) begin
            hz = 1'b1;
          end
        end
      end
    end
    x_flush = pair_valid && is_branch && branch_taken;
    x_stall = pair_valid && !x_flush && hz;
    x_dep = pair_valid && !i1[4] && !i2[4] && !x_flush && !x_stall &&
            (i1[7] == i2[7] || slot1_dst == slot2_dst);
    go = pair_valid && !x_flush && !x_stall;
    x_iss_even = go && (!i1[7] || !x_dep);
    x_iss_odd  = go && (i1[7] || !x_dep);
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < 7; p++) begin
        m_wr[0][p] <= 1'b0;
        m_wr[1][p] <= 1'b0;
      end
      x_wb_ev <= 1'b0;
      x_wb_od <= 1'b0;
      x_retired <= '0;
    end else begin
      x_wb_ev <= m_wr[0][6];
      x_wb_od <= m_wr[1][6];
      if (m_wr[0][6]) x_wb_ev_reg <= m_dst[0][6];
      if (m_wr[1][6]) x_wb_od_reg <= m_dst[1][6];
      x_retired <= x_retired + 16'(m_wr[0][6]) + 16'(m_wr[1][6]);
      for (int q = 0; q < 2; q++) begin
        for (int p = 6; p > 0; p--) begin
          m_dst[q][p] <= m_dst[q][p-1];
          m_wr[q][p]  <= m_wr[q][p-1];
          m_lat[q][p] <= m_lat[q][p-1];
        end
      end
      m_dst[0][0] <= e_dst;
      m_wr[0][0]  <= x_iss_even && e_wr;
      m_lat[0][0] <= x_iss_even ? e_lat : 4'd0;
      m_dst[1][0] <= o_dst;
      m_wr[1][0]  <= x_iss_odd && o_wr;
      m_lat[1][0] <= x_iss_odd ? o_lat : 4'd0;
    end
  end

  task automatic report_mismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
    errors++;
    $display("FAIL %s: got %h, expected %h", name, got, exp);
  endtask

  a_flush: assert property (@(posedge clk) disable iff (rst) flush == x_flush)
    else report_mismatch("flush", $sampled(flush), $sampled(x_flush));
  a_stall: assert property (@(posedge clk) disable iff (rst) stall == x_stall)
    else report_mismatch("stall", $sampled(stall), $sampled(x_stall));
  a_dep: assert property (@(posedge clk) disable iff (rst) dependent_stall == x_dep)
    else report_mismatch("dependent_stall", $sampled(dependent_stall), $sampled(x_dep));
  a_iss_even: assert property (@(posedge clk) disable iff (rst) issue_even == x_iss_even)
    else report_mismatch("issue_even", $sampled(issue_even), $sampled(x_iss_even));
  a_iss_odd: assert property (@(posedge clk) disable iff (rst) issue_odd == x_iss_odd)
    else report_mismatch("issue_odd", $sampled(issue_odd), $sampled(x_iss_odd));
  a_wb_ev: assert property (@(posedge clk) disable iff (rst) wb_even_valid == x_wb_ev)
    else report_mismatch("wb_even_valid", $sampled(wb_even_valid), $sampled(x_wb_ev));
  a_wb_od: assert property (@(posedge clk) disable iff (rst) wb_odd_valid == x_wb_od)
    else report_mismatch("wb_odd_valid", $sampled(wb_odd_valid), $sampled(x_wb_od));
  a_wb_ev_reg: assert property (@(posedge clk) disable iff (rst)
                                x_wb_ev |-> wb_even_reg == x_wb_ev_reg)
    else report_mismatch("wb_even_reg", $sampled(wb_even_reg), $sampled(x_wb_ev_reg));
  a_wb_od_reg: assert property (@(posedge clk) disable iff (rst)
                                x_wb_od |-> wb_odd_reg == x_wb_od_reg)
    else report_mismatch("wb_odd_reg", $sampled(wb_odd_reg), $sampled(x_wb_od_reg));
  a_retired: assert property (@(posedge clk) disable iff (rst) retired_count == x_retired)
    else report_mismatch("retired_count", $sampled(retired_count), $sampled(x_retired));

  task automatic stage(input int s, input logic [6:0] id, dst, ra, rb, rc);
    st_id[s]  = id;
    st_dst[s] = dst;
    st_ra[s]  = ra;
    st_rb[s]  = rb;
    st_rc[s]  = rc;
  endtask

  task automatic rand_slot(input int s);
    stage(s, instr_ids[$urandom % 11], 7'($urandom % 32), 7'($urandom % 32),
          7'($urandom % 32), 7'($urandom % 32));
  endtask

  // Presents the staged pair and holds it while the stage stalls
  task automatic send(input logic taken, output int stalls, output logic dep, output logic fl);
    @(negedge clk);
    pair_valid = 1'b1;
    slot1_id = st_id[0];
    slot1_dst = st_dst[0];
    slot1_ra = st_ra[0];
    slot1_rb = st_rb[0];
    slot1_rc = st_rc[0];
    slot2_id = st_id[1];
    slot2_dst = st_dst[1];
    slot2_ra = st_ra[1];
    slot2_rb = st_rb[1];
    slot2_rc = st_rc[1];
    is_branch = (st_id[0] == `INSTR_ID_BR) || (st_id[1] == `INSTR_ID_BR);
    branch_taken = taken;
    stalls = 0;
    #2;
    while (stall) begin
      stalls++;
      @(negedge clk);
      #2;
    end
    dep = dependent_stall;
    fl = flush;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      pair_valid = 1'b0;
      is_branch = 1'b0;
      branch_taken = 1'b0;
    end
  endtask

  initial begin : watchdog
    while (cycles < timeout_cycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int n;
    logic dep, fl, carry;
    void'($urandom(37));
    instr_ids = '{`INSTR_ID_NOP, `INSTR_ID_LNOP, `INSTR_ID_STOP, `INSTR_ID_A, `INSTR_ID_FA,
                  `INSTR_ID_FMA, `INSTR_ID_MPYA, `INSTR_ID_SELB, `INSTR_ID_SHLQBY,
                  `INSTR_ID_LQD, `INSTR_ID_BR};
    rst = 1'b1;
    {pair_valid, is_branch, branch_taken} = '0;
    {slot1_id, slot1_dst, slot1_ra, slot1_rb, slot1_rc} = '0;
    {slot2_id, slot2_dst, slot2_ra, slot2_rb, slot2_rc} = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle(3);

    stage(0, `INSTR_ID_A, 5, 1, 2, 0);
    stage(1, `INSTR_ID_LNOP, 0, 0, 0, 0);
    send(0, n, dep, fl);
    stage(0, `INSTR_ID_SHLQBY, 9, 5, 3, 0); // Reads r5 one pair later
    stage(1, `INSTR_ID_NOP, 0, 0, 0, 0);
    send(0, n, dep, fl);
    assert (n == 1) else report_mismatch("stall_cycles_a", 16'(n), 16'd1);
    stage(0, `INSTR_ID_MPYA, 6, 1, 2, 3);
    stage(1, `INSTR_ID_LNOP, 0, 0, 0, 0);
    send(0, n, dep, fl);
    stage(0, `INSTR_ID_LQD, 20, 6, 1, 0);
    stage(1, `INSTR_ID_NOP, 0, 0, 0, 0);
    send(0, n, dep, fl);
    assert (n == 6) else report_mismatch("stall_cycles_mpya", 16'(n), 16'd6);
    stage(0, `INSTR_ID_FMA, 7, 1, 2, 3);
    stage(1, `INSTR_ID_LNOP, 0, 0, 0, 0);
    send(0, n, dep, fl);
    stage(0, `INSTR_ID_A, 8, 1, 2, 7); // rc is not a source of a
    send(0, n, dep, fl);
    assert (n == 0) else report_mismatch("stall_cycles_rc_a", 16'(n), 16'd0);
    stage(0, `INSTR_ID_SELB, 21, 1, 2, 7);
    send(0, n, dep, fl);
    assert (n == 4) else report_mismatch("stall_cycles_rc_selb", 16'(n), 16'd4);

    stage(0, `INSTR_ID_FA, 10, 1, 2, 3);
    stage(1, `INSTR_ID_A, 11, 1, 2, 3);
    send(0, n, dep, fl);
    assert (dep) else report_mismatch("dependent_two_even", 16'(dep), 16'd1);
    stage(0, `INSTR_ID_A, 11, 1, 2, 3);
    stage(1, `INSTR_ID_LNOP, 0, 0, 0, 0);
    send(0, n, dep, fl);
    stage(0, `INSTR_ID_SHLQBY, 12, 1, 2, 0);
    stage(1, `INSTR_ID_A, 12, 1, 2, 0);
    send(0, n, dep, fl);
    assert (dep) else report_mismatch("dependent_same_dst", 16'(dep), 16'd1);
    stage(0, `INSTR_ID_A, 12, 1, 2, 0);
    stage(1, `INSTR_ID_LNOP, 0, 0, 0, 0);
    send(0, n, dep, fl);
    stage(0, `INSTR_ID_A, 13, 1, 2, 0);
    stage(1, `INSTR_ID_LQD, 14, 1, 2, 0);
    send(0, n, dep, fl);
    assert (!dep) else report_mismatch("dependent_independent", 16'(dep), 16'd0);

    stage(0, `INSTR_ID_BR, 0, 1, 2, 0);
    stage(1, `INSTR_ID_A, 15, 1, 2, 0);
    send(1, n, dep, fl);
    assert (fl) else report_mismatch("flush_taken", 16'(fl), 16'd1);
    send(0, n, dep, fl);
    assert (!fl) else report_mismatch("flush_not_taken", 16'(fl), 16'd0);
    idle(10);

    carry = 1'b0;
    for (int k = 0; k < 300; k++) begin
      if ($urandom % 8 == 0) idle(1);
      if (!carry) rand_slot(0);
      rand_slot(1);
      send(1'($urandom % 2), n, dep, fl);
      carry = dep;
      if (dep) stage(0, st_id[1], st_dst[1], st_ra[1], st_rb[1], st_rc[1]); // Replay slot 2
    end
    idle(12);

    $display("Checks finished: %0d errors in %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
